// File: i2c_eeprom_pkg.sv
package i2c_eeprom_pkg;

    // device type identifier carried in the top nibble of every control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // 2 KB array, 3 block bits from the control byte plus 8 word-address bits
    localparam int ADDR_W = 11;

    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } eep_op_e;

    // command presented to the master with cmd_valid
    typedef struct packed {
        eep_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } eep_cmd_t;

    // result returned with done
    typedef struct packed {
        logic [7:0] rdata;
        logic       ack_error;
    } eep_rsp_t;

    // control byte layout, MSB first on the bus
    typedef struct packed {
        logic [3:0] dev_code;
        logic [2:0] block;
        // 1 selects a read
        logic       rw;
    } ctrl_fields_t;

    // shifted in as a raw word, then decoded by field
    typedef union packed {
        logic [7:0]   raw;
        ctrl_fields_t fields;
    } ctrl_byte_u;

endpackage

// File: eeprom_array.sv
`timescale 1ns/1ps

module eeprom_array (
    input  logic                              scl,
    input  logic                              we,
    input  logic [i2c_eeprom_pkg::ADDR_W-1:0] waddr,
    input  logic [7:0]                        wdata,
    input  logic [i2c_eeprom_pkg::ADDR_W-1:0] raddr,
    output logic [7:0]                        rdata
);

    logic [7:0] mem [0:(1 << i2c_eeprom_pkg::ADDR_W)-1];

    // blank part reads as zero
    initial
    begin
        for (int i = 0; i < (1 << i2c_eeprom_pkg::ADDR_W); i++)
        begin
            mem[i] = 8'h00;
        end
    end

    always @(posedge scl)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge scl)
    begin
        rdata <= mem[raddr];
    end

endmodule

// File: eeprom_slave.sv
`timescale 1ns/1ps

module eeprom_slave (
    input  logic scl,
    input  logic rst,
    input  logic bus_clk,
    input  logic bus_dat,
    output logic slv_dat_low
);

    typedef enum logic [2:0] {
        st_idle,
        st_ctrl,
        st_addr,
        st_wdata,
        st_rdata
    } state_e;

    state_e                            state;
    logic [1:0]                        clk_q;
    logic [1:0]                        dat_q;
    logic                              clk_rise;
    logic                              clk_fall;
    logic                              start_det;
    logic                              stop_det;
    logic [3:0]                        bit_cnt;
    logic                              rx_state;
    logic                              shift_en;
    logic                              ack_fall;
    logic                              end_fall;
    i2c_eeprom_pkg::ctrl_byte_u        shift_q;
    logic [2:0]                        blk;
    logic [7:0]                        addr_byte;
    logic [i2c_eeprom_pkg::ADDR_W-1:0] mem_addr;
    logic                              we;
    logic [7:0]                        rdata;

    // two-flop sample of both lines, [0] is the newer one
    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            clk_q <= 2'b11;
            dat_q <= 2'b11;
        end
        else
        begin
            clk_q <= {clk_q[0], bus_clk};
            dat_q <= {dat_q[0], bus_dat};
        end
    end

    assign clk_rise  = clk_q[0] & ~clk_q[1];
    assign clk_fall  = ~clk_q[0] & clk_q[1];
    assign start_det = clk_q[0] & clk_q[1] & dat_q[1] & ~dat_q[0];
    assign stop_det  = clk_q[0] & clk_q[1] & ~dat_q[1] & dat_q[0];

    // states that receive a byte and acknowledge it
    assign rx_state = (state == st_ctrl) || (state == st_addr) || (state == st_wdata);
    assign shift_en = rx_state && clk_rise && (bit_cnt < 4'd8);
    assign ack_fall = rx_state && clk_fall && (bit_cnt == 4'd8);
    assign end_fall = rx_state && clk_fall && (bit_cnt == 4'd9);

    always_ff @(posedge scl)
    begin
        if (shift_en)
        begin
            shift_q.raw <= {shift_q.raw[6:0], dat_q[0]};
        end
        if (ack_fall && state == st_ctrl)
        begin
            blk <= shift_q.fields.block;
        end
        if (end_fall && state == st_addr)
        begin
            addr_byte <= shift_q.raw;
        end
    end

    assign mem_addr = {blk, addr_byte};
    // data byte lands once its ack clock is over
    assign we       = end_fall && (state == st_wdata);

    eeprom_array u_array (
        .scl   (scl),
        .we    (we),
        .waddr (mem_addr),
        .wdata (shift_q.raw),
        .raddr (mem_addr),
        .rdata (rdata)
    );

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            state       <= st_idle;
            bit_cnt     <= 4'd0;
            slv_dat_low <= 1'b0;
        end
        else if (stop_det)
        begin
            state       <= st_idle;
            slv_dat_low <= 1'b0;
        end
        else if (start_det)
        begin
            // also covers the repeated start of a random read
            state       <= st_ctrl;
            bit_cnt     <= 4'd0;
            slv_dat_low <= 1'b0;
        end
        else if (state != st_idle)
        begin
            if (clk_rise && bit_cnt < 4'd8)
            begin
                bit_cnt <= bit_cnt + 4'd1;
            end
            else if (clk_fall && state == st_rdata)
            begin
                if (bit_cnt == 4'd8)
                begin
                    // master's nack clock follows
                    slv_dat_low <= 1'b0;
                    state       <= st_idle;
                end
                else
                begin
                    slv_dat_low <= ~rdata[3'(7 - bit_cnt)];
                end
            end
            else if (ack_fall)
            begin
                if (state == st_ctrl &&
                    shift_q.fields.dev_code != i2c_eeprom_pkg::DEVICE_CODE)
                begin
                    state <= st_idle;
                end
                else
                begin
                    slv_dat_low <= 1'b1;
                    bit_cnt     <= 4'd9;
                end
            end
            else if (end_fall)
            begin
                bit_cnt <= 4'd0;
                // read control byte: first data bit goes out on this same edge
                slv_dat_low <= (state == st_ctrl && shift_q.fields.rw) ? ~rdata[7] : 1'b0;
                case (state)
                    st_ctrl:
                    begin
                        state <= shift_q.fields.rw ? st_rdata : st_addr;
                    end
                    st_addr:
                    begin
                        state <= st_wdata;
                    end
                    default:
                    begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

    // slave only moves data while the clock is low
    a_dat_stable_clk_high: assert property (@(posedge scl) disable iff (rst)
        bus_clk |-> $stable(slv_dat_low));

endmodule

// File: i2c_master.sv
`timescale 1ns/1ps

module i2c_master #(
    parameter int CLK_DIV = 4
) (
    input  logic                     scl,
    input  logic                     rst,
    input  logic                     cmd_valid,
    input  i2c_eeprom_pkg::eep_cmd_t cmd,
    output logic                     busy,
    output logic                     done,
    output i2c_eeprom_pkg::eep_rsp_t rsp,
    input  logic                     bus_clk,
    input  logic                     bus_dat,
    output logic                     mst_clk_low,
    output logic                     mst_dat_low
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    typedef enum logic [1:0] {
        ph_idle,
        ph_start,
        ph_bit,
        ph_stop
    } phase_e;

    phase_e                       phase;
    logic [DIV_W-1:0]             div_cnt;
    logic                         tick;
    logic                         accept;
    logic [1:0]                   quarter;
    logic [3:0]                   bit_idx;
    logic [1:0]                   byte_idx;
    i2c_eeprom_pkg::eep_cmd_t     cmd_q;
    i2c_eeprom_pkg::ctrl_fields_t ctrl;
    logic [7:0]                   tx_byte;
    logic                         is_read;
    logic                         rd_byte;
    logic                         last_byte;

    assign accept = (phase == ph_idle) && !busy && cmd_valid;

    // quarter-bit pacing
    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            div_cnt <= '0;
        end
        else if (phase == ph_idle || tick)
        begin
            div_cnt <= '0;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign tick = (phase != ph_idle) && (div_cnt == DIV_W'(CLK_DIV - 1));

    always_ff @(posedge scl)
    begin
        if (accept)
        begin
            cmd_q <= cmd;
        end
    end

    assign is_read   = (cmd_q.op == i2c_eeprom_pkg::op_read);
    assign rd_byte   = is_read && (byte_idx == 2'd3);
    assign last_byte = is_read ? (byte_idx == 2'd3) : (byte_idx == 2'd2);

    // byte order: ctrl(w), word addr, then data or ctrl(r)
    always_comb
    begin
        ctrl.dev_code = i2c_eeprom_pkg::DEVICE_CODE;
        ctrl.block    = cmd_q.addr[i2c_eeprom_pkg::ADDR_W-1:8];
        ctrl.rw       = (byte_idx == 2'd2);
        case (byte_idx)
            2'd0:    tx_byte = 8'(ctrl);
            2'd1:    tx_byte = cmd_q.addr[7:0];
            2'd2:    tx_byte = is_read ? 8'(ctrl) : cmd_q.wdata;
            default: tx_byte = 8'h00;
        endcase
    end

    // each bit: q0 clk low, q1 data, q2 clk high, q3 sample
    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            phase       <= ph_idle;
            quarter     <= 2'd0;
            bit_idx     <= 4'd0;
            byte_idx    <= 2'd0;
            busy        <= 1'b0;
            done        <= 1'b0;
            rsp         <= '0;
            mst_clk_low <= 1'b0;
            mst_dat_low <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (done)
            begin
                busy <= 1'b0;
            end
            if (accept)
            begin
                busy          <= 1'b1;
                phase         <= ph_start;
                quarter       <= 2'd0;
                bit_idx       <= 4'd0;
                byte_idx      <= 2'd0;
                rsp.ack_error <= 1'b0;
                mst_clk_low   <= 1'b1;
            end
            else if (tick)
            begin
                quarter <= quarter + 2'd1;
                case (quarter)
                    2'd0:
                    begin
                        case (phase)
                            ph_start: mst_dat_low <= 1'b0;
                            ph_stop:  mst_dat_low <= 1'b1;
                            // released for read bits, slave ack and our nack
                            default:  mst_dat_low <= (bit_idx < 4'd8 && !rd_byte) ?
                                                     ~tx_byte[3'(7 - bit_idx)] : 1'b0;
                        endcase
                    end
                    2'd1:
                    begin
                        mst_clk_low <= 1'b0;
                    end
                    2'd2:
                    begin
                        case (phase)
                            ph_start: mst_dat_low <= 1'b1;
                            ph_stop:  mst_dat_low <= 1'b0;
                            default:
                            begin
                                if (bus_clk && bit_idx < 4'd8 && rd_byte)
                                begin
                                    rsp.rdata <= {rsp.rdata[6:0], bus_dat};
                                end
                                else if (bus_clk && bit_idx == 4'd8 && !rd_byte && bus_dat)
                                begin
                                    rsp.ack_error <= 1'b1;
                                end
                            end
                        endcase
                    end
                    default:
                    begin
                        case (phase)
                            ph_start:
                            begin
                                phase       <= ph_bit;
                                bit_idx     <= 4'd0;
                                mst_clk_low <= 1'b1;
                            end
                            ph_bit:
                            begin
                                mst_clk_low <= 1'b1;
                                if (bit_idx != 4'd8)
                                begin
                                    bit_idx <= bit_idx + 4'd1;
                                end
                                else
                                begin
                                    bit_idx <= 4'd0;
                                    if (rsp.ack_error || last_byte)
                                    begin
                                        phase <= ph_stop;
                                    end
                                    else if (is_read && byte_idx == 2'd1)
                                    begin
                                        // repeated start before the read control byte
                                        phase    <= ph_start;
                                        byte_idx <= 2'd2;
                                    end
                                    else
                                    begin
                                        byte_idx <= byte_idx + 2'd1;
                                    end
                                end
                            end
                            default:
                            begin
                                phase <= ph_idle;
                                done  <= 1'b1;
                            end
                        endcase
                    end
                endcase
            end
        end
    end

    a_no_cmd_while_busy: assert property (@(posedge scl) disable iff (rst)
        cmd_valid |-> !busy);

    a_done_single: assert property (@(posedge scl) disable iff (rst)
        done |=> !done);

endmodule

// File: i2c_eeprom_top.sv
`timescale 1ns/1ps

module i2c_eeprom_top #(
    parameter int CLK_DIV = 4
) (
    input  logic                     scl,
    input  logic                     rst,
    input  logic                     cmd_valid,
    input  i2c_eeprom_pkg::eep_cmd_t cmd,
    output logic                     busy,
    output logic                     done,
    output i2c_eeprom_pkg::eep_rsp_t rsp
);

    logic mst_clk_low;
    logic mst_dat_low;
    logic slv_dat_low;
    logic bus_clk;
    logic bus_dat;

    // open-drain lines, any driver pulls low
    assign bus_clk = ~mst_clk_low;
    assign bus_dat = ~(mst_dat_low | slv_dat_low);

    i2c_master #(
        .CLK_DIV (CLK_DIV)
    ) u_master (
        .scl         (scl),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .busy        (busy),
        .done        (done),
        .rsp         (rsp),
        .bus_clk     (bus_clk),
        .bus_dat     (bus_dat),
        .mst_clk_low (mst_clk_low),
        .mst_dat_low (mst_dat_low)
    );

    eeprom_slave u_slave (
        .scl         (scl),
        .rst         (rst),
        .bus_clk     (bus_clk),
        .bus_dat     (bus_dat),
        .slv_dat_low (slv_dat_low)
    );

endmodule

// File: tb_i2c_eeprom.sv
`timescale 1ns/1ps

module tb_i2c_eeprom;

    localparam int CLK_DIV      = 4;
    localparam int BITS_PER_CMD = 40;
    localparam int MEM_DEPTH    = 1 << i2c_eeprom_pkg::ADDR_W;

    logic                     scl;
    logic                     rst;
    logic                     cmd_valid;
    i2c_eeprom_pkg::eep_cmd_t cmd;
    logic                     busy;
    logic                     done;
    i2c_eeprom_pkg::eep_rsp_t rsp;

    int unsigned op_q[$];
    int unsigned addr_q[$];
    int unsigned wdata_q[$];
    int unsigned exp_q[$];
    logic [7:0]  ref_mem [0:MEM_DEPTH-1];
    int          cycles;
    int          cycle_limit;
    int          done_seen;
    logic        cmd_started;

    i2c_eeprom_top #(
        .CLK_DIV (CLK_DIV)
    ) u_i2c_eeprom_top (
        .scl       (scl),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp)
    );

    always #5 scl = ~scl;

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (expected == actual)
        else
        begin
            $display("ERR t=%0t %s expected %0h got %0h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // columns: op addr wdata expected, all hex, # starts a comment line
    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        int unsigned f_op;
        int unsigned f_addr;
        int unsigned f_wdata;
        int unsigned f_exp;
        fd = $fopen("test_input.txt", "r");
        assert (fd != 0)
        else
        begin
            $display("could not open the stimulus file test_input.txt");
            abort_run();
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#")
            begin
                n = $sscanf(line, "%h %h %h %h", f_op, f_addr, f_wdata, f_exp);
                if (n == 4)
                begin
                    op_q.push_back(f_op);
                    addr_q.push_back(f_addr);
                    wdata_q.push_back(f_wdata);
                    exp_q.push_back(f_exp);
                end
            end
        end
        $fclose(fd);
        assert (op_q.size() > 0)
        else
        begin
            $display("the stimulus file holds no commands");
            abort_run();
        end
    endtask

    task automatic run_command(int idx);
        logic [i2c_eeprom_pkg::ADDR_W-1:0] addr;
        logic [7:0]                        wdata;
        logic [7:0]                        exp;
        logic                              is_read;
        addr    = i2c_eeprom_pkg::ADDR_W'(addr_q[idx]);
        wdata   = 8'(wdata_q[idx]);
        exp     = 8'(exp_q[idx]);
        is_read = (op_q[idx] != 0);
        while (busy)
        begin
            @(negedge scl);
        end
        @(posedge scl);
        #1;
        // no stray done since the last command
        check_value("done", idx, done_seen);
        cmd_started = 1'b1;
        cmd_valid   = 1'b1;
        cmd.op      = is_read ? i2c_eeprom_pkg::op_read : i2c_eeprom_pkg::op_write;
        cmd.addr    = addr;
        cmd.wdata   = wdata;
        @(posedge scl);
        #1;
        cmd_valid = 1'b0;
        @(negedge scl);
        while (!done)
        begin
            @(negedge scl);
        end
        check_value("rsp.ack_error", 0, rsp.ack_error);
        if (is_read)
        begin
            check_value("expected data in test_input.txt", ref_mem[addr], exp);
            check_value("rsp.rdata", exp, rsp.rdata);
        end
        else
        begin
            ref_mem[addr] = wdata;
        end
        @(negedge scl);
        check_value("busy", 0, busy);
    endtask

    always @(negedge scl)
    begin
        if (done)
        begin
            done_seen++;
        end
        // quiet bus before the first command
        if (!rst && !cmd_started)
        begin
            check_value("busy", 0, busy);
            check_value("done", 0, done);
        end
    end

    always @(posedge scl)
    begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            abort_run();
        end
    end

    initial
    begin
        scl         = 1'b0;
        rst         = 1'b1;
        cmd_valid   = 1'b0;
        cmd         = '0;
        cmd_started = 1'b0;
        cycles      = 0;
        cycle_limit = 0;
        done_seen   = 0;
        for (int i = 0; i < MEM_DEPTH; i++)
        begin
            ref_mem[i] = 8'h00;
        end
        load_stimulus();
        cycle_limit = op_q.size() * BITS_PER_CMD * 4 * CLK_DIV + 200;
        repeat (8) @(posedge scl);
        #1;
        rst = 1'b0;
        repeat (20) @(posedge scl);
        for (int i = 0; i < op_q.size(); i++)
        begin
            run_command(i);
        end
        repeat (10) @(posedge scl);
        #1;
        check_value("done", op_q.size(), done_seen);
        $display("All tests passed");
        $finish;
    end

endmodule

// File: test_input.txt
# columns: op (0 write, 1 read), address (hex, 11 bits), write data (hex), expected read data (hex)
# write lines carry 00 as expected data, read lines carry 00 as write data
0 012 a5 00
1 012 00 a5
0 045 11 00
0 145 22 00
0 745 77 00
1 045 00 11
1 145 00 22
1 745 00 77
0 3c0 5a 00
0 3c0 c3 00
1 3c0 00 c3
1 6ff 00 00
1 000 00 00
0 7ff ff 00
1 7ff 00 ff
0 000 01 00
1 000 00 01
1 245 00 00
0 2aa 3c 00
1 2aa 00 3c

// File: verilog.f
i2c_eeprom_pkg.sv
eeprom_array.sv
eeprom_slave.sv
i2c_master.sv
i2c_eeprom_top.sv
tb_i2c_eeprom.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_i2c_eeprom -f verilog.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
